// File: rtl/vga_timing_pkg.sv
// vga display timing definitions
// 640x400 text timing at one pixel per clock, syncs active low
`default_nettype none

package vga_timing_pkg;

  // horizontal, in clocks
  localparam logic [9:0] H_TOTAL    = 10'd800;
  localparam logic [9:0] H_DISP     = 10'd640;
  localparam logic [9:0] H_SYNC_BEG = 10'd656;
  localparam logic [9:0] H_SYNC_END = 10'd752;  // first count after hsync

  // vertical, in lines
  localparam logic [9:0] V_TOTAL    = 10'd449;
  localparam logic [9:0] V_DISP     = 10'd400;
  localparam logic [9:0] V_SYNC_BEG = 10'd412;
  localparam logic [9:0] V_SYNC_END = 10'd414;

  typedef struct packed {
    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       hsync_n;
    logic       vsync_n;
    logic       video_on;
    logic       fetch_restart;  // one clock at start of line V_SYNC_BEG
  } crt_timing_t;

endpackage

`default_nettype wire

// File: rtl/vga_text_pkg.sv
// vga text mode definitions
// screen geometry, cell and wishbone bus types, fetch states
`default_nettype none

package vga_text_pkg;

  localparam int unsigned COLS   = 80;
  localparam int unsigned ROWS   = 25;
  localparam int unsigned CELL_H = 16;  // scan rows per character

  // one scan row of one character
  typedef struct packed {
    logic [7:0] glyph;  // bit 7 is leftmost pixel
    logic [7:0] attr;
  } text_cell_t;

  // wishbone classic master request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [16:0] adr;  // word address
  } wb_req_t;

  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_CHAR,
    FETCH_FONT,
    FETCH_PUSH
  } fetch_state_e;

endpackage

`default_nettype wire

// File: rtl/vga_crtc_timing.sv
// crt timing generator
// free running h/v counters with registered syncs, video enable
// and the per-frame fetch restart pulse
`timescale 1ns/1ps
`default_nettype none

module vga_crtc_timing (
  input  wire logic                  clk_50,
  input  wire logic                  rst,
  output vga_timing_pkg::crt_timing_t timing_o
);

  import vga_timing_pkg::*;

  logic [9:0] h_next;
  logic [9:0] v_next;
  logic       line_end;

  assign line_end = (timing_o.h_count == H_TOTAL - 10'd1);

  always_comb
  begin
    h_next = line_end ? 10'd0 : timing_o.h_count + 10'd1;
    v_next = timing_o.v_count;
    if (line_end)
    begin
      // wrap at end of frame
      if (timing_o.v_count == V_TOTAL - 10'd1)
        v_next = 10'd0;
      else
        v_next = timing_o.v_count + 10'd1;
    end
  end

  // outputs registered from next counts so every field matches its counters
  always_ff @(posedge clk_50)
  begin
    if (rst)
    begin
      timing_o.h_count       <= 10'd0;
      timing_o.v_count       <= 10'd0;
      timing_o.hsync_n       <= 1'b1;
      timing_o.vsync_n       <= 1'b1;
      timing_o.video_on      <= 1'b1;  // h0/v0 is a visible pixel
      timing_o.fetch_restart <= 1'b0;
    end
    else
    begin
      timing_o.h_count       <= h_next;
      timing_o.v_count       <= v_next;
      timing_o.hsync_n       <= !((h_next >= H_SYNC_BEG) && (h_next < H_SYNC_END));
      timing_o.vsync_n       <= !((v_next >= V_SYNC_BEG) && (v_next < V_SYNC_END));
      timing_o.video_on      <= (h_next < H_DISP) && (v_next < V_DISP);
      timing_o.fetch_restart <= (h_next == 10'd0) && (v_next == V_SYNC_BEG);
    end
  end

endmodule

`default_nettype wire

// File: rtl/vga_text_fetch.sv
// text fetcher
// wishbone classic read master that walks the screen one scan row at a
// time, reading the char/attr word and then the font byte for each cell
`timescale 1ns/1ps
`default_nettype none

module vga_text_fetch #(
  parameter logic [16:0] TEXT_BASE = 17'h08000,
  parameter logic [16:0] FONT_BASE = 17'h00000
) (
  input  wire logic                   clk_50,
  input  wire logic                   rst,
  input  wire vga_timing_pkg::crt_timing_t timing_i,
  output vga_text_pkg::wb_req_t       wb_req_o,
  input  wire vga_text_pkg::wb_rsp_t  wb_rsp_i,
  output vga_text_pkg::text_cell_t    cell_o,
  output logic                        push_o,
  input  wire logic                   full_i
);

  import vga_text_pkg::*;

  fetch_state_e state;
  logic         busy;       // cyc and stb up
  logic [6:0]   col;
  logic [3:0]   scan;
  logic [4:0]   row;
  logic [7:0]   char_q;
  logic [16:0]  text_adr;
  logic [16:0]  font_adr;
  logic         last_cell;
  logic         bus_done;

  assign text_adr  = TEXT_BASE + 17'(row) * 17'(COLS) + 17'(col);
  assign font_adr  = FONT_BASE + {5'd0, char_q, scan};  // char * 16 + scan
  assign last_cell = (col == 7'(COLS - 1)) && (scan == 4'(CELL_H - 1))
                     && (row == 5'(ROWS - 1));
  assign bus_done  = busy && wb_rsp_i.ack;

  always_comb
  begin
    wb_req_o.cyc = busy;
    wb_req_o.stb = busy;
    wb_req_o.we  = 1'b0;  // read only
    wb_req_o.adr = (state == FETCH_FONT) ? font_adr : text_adr;
  end

  assign push_o = (state == FETCH_PUSH) && !full_i;

  always_ff @(posedge clk_50)
  begin
    if (rst)
    begin
      state <= FETCH_IDLE;
      busy  <= 1'b0;
      col   <= 7'd0;
      scan  <= 4'd0;
      row   <= 5'd0;
    end
    else if (timing_i.fetch_restart)
    begin
      // any open cycle is dropped; CHAR raises a fresh one next clock
      state <= FETCH_CHAR;
      busy  <= 1'b0;
      col   <= 7'd0;
      scan  <= 4'd0;
      row   <= 5'd0;
    end
    else
    begin
      case (state)
        FETCH_CHAR, FETCH_FONT:
        begin
          if (!busy)
            busy <= 1'b1;
          else if (wb_rsp_i.ack)
          begin
            busy  <= 1'b0;  // one idle clock between transfers
            state <= (state == FETCH_CHAR) ? FETCH_FONT : FETCH_PUSH;
          end
        end
        FETCH_PUSH:
        begin
          if (!full_i)  // else hold, back-pressure
          begin
            if (last_cell)
              state <= FETCH_IDLE;
            else
            begin
              state <= FETCH_CHAR;
              busy  <= 1'b1;  // push clock served as the idle clock
            end
            if (col == 7'(COLS - 1))
            begin
              col <= 7'd0;
              if (scan == 4'(CELL_H - 1))
              begin
                scan <= 4'd0;
                row  <= row + 5'd1;
              end
              else
                scan <= scan + 4'd1;
            end
            else
              col <= col + 7'd1;
          end
        end
        default: state <= FETCH_IDLE;  // wait for next frame
      endcase
    end
  end

  // read data capture
  always_ff @(posedge clk_50)
  begin
    if (bus_done)
    begin
      if (state == FETCH_CHAR)
      begin
        char_q      <= wb_rsp_i.dat[7:0];
        cell_o.attr <= wb_rsp_i.dat[15:8];
      end
      else
        cell_o.glyph <= wb_rsp_i.dat[7:0];
    end
  end

endmodule

`default_nettype wire

// File: rtl/vga_cell_fifo.sv
// text cell fifo
// circular buffer between fetcher and shifter, cleared once per frame
`timescale 1ns/1ps
`default_nettype none

module vga_cell_fifo #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire logic                     clk_50,
  input  wire logic                     rst,
  input  wire logic                     clear_i,
  input  wire logic                     push_i,
  input  wire vga_text_pkg::text_cell_t cell_i,
  input  wire logic                     pop_i,
  output vga_text_pkg::text_cell_t      cell_o,
  output logic                          full_o,
  output logic                          empty_o
);

  import vga_text_pkg::*;

  localparam int unsigned AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] DEPTH_CNT = FIFO_DEPTH[AW:0];

  text_cell_t    mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count == DEPTH_CNT);
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;   // push while full dropped
  assign do_pop  = pop_i && !empty_o;
  assign cell_o  = mem[rd_ptr];         // head, valid when not empty

  always_ff @(posedge clk_50)
  begin
    if (do_push)
      mem[wr_ptr] <= cell_i;
  end

  always_ff @(posedge clk_50)
  begin
    if (rst || clear_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/vga_text_shifter.sv
// text pixel shifter
// pops one cell per 8 visible pixels, serializes the glyph into
// 4-bit color indices and delays syncs to match, two clocks in total
`timescale 1ns/1ps
`default_nettype none

module vga_text_shifter (
  input  wire logic                        clk_50,
  input  wire logic                        rst,
  input  wire vga_timing_pkg::crt_timing_t timing_i,
  input  wire vga_text_pkg::text_cell_t    cell_i,
  input  wire logic                        empty_i,
  output logic                             pop_o,
  output logic [3:0]                       color_o,
  output logic                             hsync_n_o,
  output logic                             vsync_n_o,
  output logic                             video_on_o,
  output logic                             underrun_o
);

  import vga_timing_pkg::*;

  crt_timing_t d1;          // timing, first stage
  logic        frame_live;  // set once fetcher has run its first frame
  logic        cell_edge;
  logic [7:0]  glyph_sr;
  logic [7:0]  attr_q;
  logic [3:0]  pix;

  assign cell_edge = timing_i.video_on && (timing_i.h_count[2:0] == 3'd0);
  assign pop_o     = cell_edge && frame_live;
  // fg in attr[3:0], bg in attr[6:4], attr[7] unused
  assign pix       = glyph_sr[7] ? attr_q[3:0] : {1'b0, attr_q[6:4]};

  always_ff @(posedge clk_50)
  begin
    if (cell_edge)
    begin
      if (pop_o && !empty_i)
      begin
        glyph_sr <= cell_i.glyph;
        attr_q   <= cell_i.attr;
      end
      else
      begin
        glyph_sr <= 8'd0;  // blank cell
        attr_q   <= 8'd0;
      end
    end
    else
      glyph_sr <= {glyph_sr[6:0], 1'b0};
  end

  always_ff @(posedge clk_50)
  begin
    if (rst)
    begin
      d1         <= '{h_count: 10'd0, v_count: 10'd0, hsync_n: 1'b1, vsync_n: 1'b1,
                      video_on: 1'b0, fetch_restart: 1'b0};
      frame_live <= 1'b0;
      underrun_o <= 1'b0;
      color_o    <= 4'd0;
      hsync_n_o  <= 1'b1;
      vsync_n_o  <= 1'b1;
      video_on_o <= 1'b0;
    end
    else
    begin
      d1 <= timing_i;
      if (timing_i.fetch_restart)
        frame_live <= 1'b1;
      if (pop_o && empty_i)
        underrun_o <= 1'b1;  // sticky
      color_o    <= d1.video_on ? pix : 4'd0;
      hsync_n_o  <= d1.hsync_n;
      vsync_n_o  <= d1.vsync_n;
      video_on_o <= d1.video_on;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vga_text_top.sv
// vga text mode video path
// timing generator, wishbone text fetcher, cell fifo and pixel shifter
`timescale 1ns/1ps
`default_nettype none

module vga_text_top #(
  parameter logic [16:0] TEXT_BASE  = 17'h08000,
  parameter logic [16:0] FONT_BASE  = 17'h00000,
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire logic                    clk_50,
  input  wire logic                    rst,
  output vga_text_pkg::wb_req_t        wb_req_o,
  input  wire vga_text_pkg::wb_rsp_t   wb_rsp_i,
  output logic [3:0]                   color_o,
  output logic                         hsync_n_o,
  output logic                         vsync_n_o,
  output logic                         video_on_o,
  output logic                         underrun_o
);

  import vga_timing_pkg::*;
  import vga_text_pkg::*;

  crt_timing_t timing;
  text_cell_t  fetch_cell;
  text_cell_t  head_cell;
  logic        push;
  logic        pop;
  logic        full;
  logic        empty;

  vga_crtc_timing crtc0 (
    .clk_50   (clk_50),
    .rst      (rst),
    .timing_o (timing)
  );

  vga_text_fetch #(
    .TEXT_BASE (TEXT_BASE),
    .FONT_BASE (FONT_BASE)
  ) fetch0 (
    .clk_50   (clk_50),
    .rst      (rst),
    .timing_i (timing),
    .wb_req_o (wb_req_o),
    .wb_rsp_i (wb_rsp_i),
    .cell_o   (fetch_cell),
    .push_o   (push),
    .full_i   (full)
  );

  // flushed at each frame restart
  vga_cell_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk_50  (clk_50),
    .rst     (rst),
    .clear_i (timing.fetch_restart),
    .push_i  (push),
    .cell_i  (fetch_cell),
    .pop_i   (pop),
    .cell_o  (head_cell),
    .full_o  (full),
    .empty_o (empty)
  );

  vga_text_shifter shift0 (
    .clk_50     (clk_50),
    .rst        (rst),
    .timing_i   (timing),
    .cell_i     (head_cell),
    .empty_i    (empty),
    .pop_o      (pop),
    .color_o    (color_o),
    .hsync_n_o  (hsync_n_o),
    .vsync_n_o  (vsync_n_o),
    .video_on_o (video_on_o),
    .underrun_o (underrun_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_vga_text.sv
// testbench for the vga text mode video path
// video memory modeled as a wishbone classic slave with set or random
// wait states; sync timing and every visible pixel of a frame are checked
`timescale 1ns/1ps
`default_nettype none

module tb_vga_text;

  localparam logic [16:0] TEXT_BASE  = 17'h08000;
  localparam logic [16:0] FONT_BASE  = 17'h00000;
  localparam int          FIFO_DEPTH = 16;

  localparam int H_PERIOD  = 800;
  localparam int H_VIS     = 640;
  localparam int HSYNC_LEN = 96;
  localparam int V_LINES   = 449;
  localparam int V_VIS     = 400;
  localparam int VSYNC_LEN = 2;  // lines
  localparam int FRAME_CYC = H_PERIOD * V_LINES;
  localparam int MEM_WORDS = 131072;

  logic                  clk_50;
  logic                  rst;
  vga_text_pkg::wb_req_t wb_req;
  vga_text_pkg::wb_rsp_t wb_rsp;
  logic [3:0]            color;
  logic                  hsync_n;
  logic                  vsync_n;
  logic                  video_on;
  logic                  underrun;

  logic [15:0] mem [MEM_WORDS];
  logic [31:0] lfsr_state;
  int          wait_fixed;   // wait states per read
  logic        wait_random;  // 0..3 from lfsr instead

  vga_text_top #(
    .TEXT_BASE  (TEXT_BASE),
    .FONT_BASE  (FONT_BASE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk_50     (clk_50),
    .rst        (rst),
    .wb_req_o   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .color_o    (color),
    .hsync_n_o  (hsync_n),
    .vsync_n_o  (vsync_n),
    .video_on_o (video_on),
    .underrun_o (underrun)
  );

  initial
  begin
    clk_50 = 1'b0;
    forever #5 clk_50 = ~clk_50;
  end

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    else
      return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] val);
    int i;
    val = 16'd0;
    for (i = 0; i < n; i++)
    begin
      val        = {val[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic fill_memory();
    logic [15:0] w;
    int          a;
    lfsr_state = 32'hd86f09ac;
    for (a = 0; a < MEM_WORDS; a++)
    begin
      draw_bits(16, w);
      mem[a] = w;
    end
  endtask

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_values(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %0h actual %0h", test, exp, act);
      stop_with_failure();
    end
  endtask

  // pixel from char/attr word and font row at screen position x, y
  function automatic logic [3:0] expected_color(input int x, input int y);
    logic [15:0] text_w;
    logic [15:0] font_w;
    logic [7:0]  attr;
    int          ch;
    text_w = mem[int'(TEXT_BASE) + (y / 16) * 80 + x / 8];
    ch     = int'(text_w[7:0]);
    attr   = text_w[15:8];
    font_w = mem[int'(FONT_BASE) + ch * 16 + y % 16];
    if (font_w[7 - x % 8])
      return attr[3:0];
    else
      return {1'b0, attr[6:4]};  // bit 7 of attr unused
  endfunction

  // wishbone classic slave answering on the falling edge
  initial
  begin : wb_slave
    int          wait_cnt;
    int          wait_tgt;
    logic        in_xfer;
    logic [16:0] xfer_adr;
    logic [15:0] rnd;
    wb_rsp   = '0;
    wait_cnt = 0;
    wait_tgt = 0;
    in_xfer  = 1'b0;
    xfer_adr = '0;
    forever
    begin
      @(negedge clk_50);
      if (wb_rsp.ack || !wb_req.cyc)
      begin
        if (wb_rsp.ack)  // master must drop cyc after ack
          compare_values("wishbone_protocol", 32'd0, 32'(wb_req.cyc));
        wb_rsp.ack = 1'b0;
        in_xfer    = 1'b0;
        wait_cnt   = 0;
      end
      else if (wb_req.stb)
      begin
        if (!in_xfer)
        begin
          in_xfer  = 1'b1;
          xfer_adr = wb_req.adr;
          if (wait_random)
          begin
            draw_bits(2, rnd);
            wait_tgt = int'(rnd[1:0]);
          end
          else
            wait_tgt = wait_fixed;
        end
        compare_values("wishbone_protocol", 32'd0, 32'(wb_req.we));
        compare_values("wishbone_protocol", 32'(xfer_adr), 32'(wb_req.adr));
        if (wait_cnt >= wait_tgt)
        begin
          wb_rsp.dat = mem[wb_req.adr];
          wb_rsp.ack = 1'b1;
        end
        else
          wait_cnt++;
      end
    end
  end

  task automatic wait_vsync_fall(input string test);
    int n;
    n = 0;
    @(negedge clk_50);
    while (!vsync_n)
    begin
      n++;
      if (n > FRAME_CYC)
      begin
        $display("%s: vsync_n_o stayed low for more than a frame", test);
        stop_with_failure();
      end
      @(negedge clk_50);
    end
    while (vsync_n)
    begin
      n++;
      if (n > 2 * FRAME_CYC)
      begin
        $display("%s: no vsync pulse within a frame time", test);
        stop_with_failure();
      end
      @(negedge clk_50);
    end
  endtask

  task automatic check_idle_outputs(input string test);
    compare_values(test, 32'd0, 32'({wb_req.cyc, wb_req.stb}));
    compare_values(test, 32'd3, 32'({hsync_n, vsync_n}));
    compare_values(test, 32'd0, 32'({video_on, underrun}));
  endtask

  task automatic reset_state();
    int i;
    for (i = 0; i < 16; i++)
    begin
      @(negedge clk_50);
      check_idle_outputs("reset_state");
      if (i == 15)
        rst = 1'b0;
    end
    @(negedge clk_50);
    check_idle_outputs("reset_state");
  endtask

  // one frame from vsync fall to the next
  task automatic sync_timing();
    int   n;
    int   lines;
    int   vis_lines;
    int   vs_low;
    int   hs_low;
    int   vid_run;
    int   hs_period;
    logic hs_prev;
    logic vs_prev;
    logic vo_prev;
    logic done;
    wait_vsync_fall("sync_timing");
    n         = 0;
    lines     = 0;
    vis_lines = 0;
    vs_low    = 1;
    hs_low    = 0;
    vid_run   = 0;
    hs_period = -1;  // no hsync edge yet
    hs_prev   = hsync_n;
    vs_prev   = 1'b0;
    vo_prev   = video_on;
    done      = 1'b0;
    while (!done)
    begin
      @(negedge clk_50);
      n++;
      if (n > FRAME_CYC + H_PERIOD)
      begin
        $display("sync_timing: next vsync fall not seen within a frame time");
        stop_with_failure();
      end
      if (!vsync_n && vs_prev)
        done = 1'b1;
      else
      begin
        if (!vsync_n)
          vs_low++;
        if (!hsync_n)
          hs_low++;
        if (hsync_n && !hs_prev)
        begin
          compare_values("sync_timing", HSYNC_LEN, hs_low);
          hs_low = 0;
        end
        if (!hsync_n && hs_prev)
        begin
          if (hs_period >= 0)
            compare_values("sync_timing", H_PERIOD, hs_period);
          hs_period = 0;
          lines++;
        end
        if (hs_period >= 0)
          hs_period++;
        if (video_on)
          vid_run++;
        if (!video_on && vo_prev)
        begin
          compare_values("sync_timing", H_VIS, vid_run);
          vid_run = 0;
          vis_lines++;
        end
      end
      hs_prev = hsync_n;
      vs_prev = vsync_n;
      vo_prev = video_on;
    end
    compare_values("sync_timing", VSYNC_LEN * H_PERIOD, vs_low);
    compare_values("sync_timing", V_LINES, lines);
    compare_values("sync_timing", V_VIS, vis_lines);
  endtask

  task automatic check_frame_pixels(input string test);
    int x;
    int y;
    int n;
    x = 0;
    y = 0;
    n = 0;
    wait_vsync_fall(test);
    while (!video_on)
    begin
      n++;
      if (n > FRAME_CYC)
      begin
        $display("%s: video_on_o never rose after vsync", test);
        stop_with_failure();
      end
      @(negedge clk_50);
    end
    while (y < V_VIS)
    begin
      if (video_on)
      begin
        compare_values(test, 32'(expected_color(x, y)), 32'(color));
        x++;
        if (x == H_VIS)
        begin
          x = 0;
          y++;
        end
      end
      else
        compare_values(test, 32'd0, 32'(color));  // blanking
      n++;
      if (n > 2 * FRAME_CYC)
      begin
        $display("%s: visible area not complete within a frame time", test);
        stop_with_failure();
      end
      if (y < V_VIS)
        @(negedge clk_50);
    end
    compare_values(test, 32'd0, 32'(underrun));
  endtask

  task automatic frame_pixels_fast();
    wait_random = 1'b0;
    wait_fixed  = 0;
    check_frame_pixels("frame_pixels_fast");
  endtask

  task automatic frame_pixels_slow();
    wait_random = 1'b1;
    check_frame_pixels("frame_pixels_slow");
  endtask

  task automatic starved_memory();
    int n;
    wait_random = 1'b0;
    wait_fixed  = 30;
    wait_vsync_fall("starved_memory");
    n = 0;
    while (!underrun)
    begin
      n++;
      if (n > FRAME_CYC)
      begin
        $display("starved_memory: underrun_o did not rise within one frame");
        stop_with_failure();
      end
      @(negedge clk_50);
    end
    wait_vsync_fall("starved_memory");
    for (n = 0; n < FRAME_CYC; n++)
    begin
      compare_values("starved_memory", 32'd1, 32'(underrun));  // sticky
      @(negedge clk_50);
    end
  endtask

  initial
  begin
    rst         = 1'b1;
    wait_fixed  = 0;
    wait_random = 1'b0;
    fill_memory();
    reset_state();
    sync_timing();
    frame_pixels_fast();
    frame_pixels_slow();
    starved_memory();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vga_text_top.f
rtl/vga_timing_pkg.sv
rtl/vga_text_pkg.sv
rtl/vga_crtc_timing.sv
rtl/vga_text_fetch.sv
rtl/vga_cell_fifo.sv
rtl/vga_text_shifter.sv
rtl/vga_text_top.sv
verif/tb_vga_text.sv

// File: run_sim.sh
#!/bin/sh
# build the vga text testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vga_text \
  -f vga_text_top.f --Mdir obj_dir -o tb_vga_text
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_vga_text
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation run failed with status $status"
  exit "$status"
fi
exit 0
